// ==== rtl/cpu_subsystem.sv ====
////////////////////////////////////////////////////////////////////////////
// Multi-cycle core sequencer with OBI fetch and data ports
// and its register file
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "mcu_params.svh"

module cpu_subsystem (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               fetch_enable_i,
    output obi_pkg::obi_req_t  core_instr_req_o,
    input  obi_pkg::obi_resp_t core_instr_resp_i,
    output obi_pkg::obi_req_t  core_data_req_o,
    input  obi_pkg::obi_resp_t core_data_resp_i,
    output logic               core_sleep_o
);
    import mini_isa_pkg::*;

    core_state_e state_q;
    core_state_e state_d;
    logic [31:0] pc_q;
    instr_u      instr_q;

    opcode_e     opcode;
    logic        is_alu;
    logic        is_mem;
    logic        is_store;
    logic [31:0] imm_sext;
    logic [31:0] alu_result;
    logic [31:0] addr_sum;

    logic [2:0]  rf_raddr_a;
    logic [2:0]  rf_raddr_b;
    logic [2:0]  rf_waddr;
    logic        rf_we;
    logic [31:0] rf_wdata;
    logic [31:0] rf_rdata_a;
    logic [31:0] rf_rdata_b;

    // Opcode and rs1 sit at the same bits in both forms
    assign opcode   = instr_q.r.opcode;
    assign imm_sext = {{16{instr_q.i.imm[15]}}, instr_q.i.imm};
    assign is_mem   = (opcode == LW) || (opcode == SW);
    assign is_store = (opcode == SW);

    always_comb begin
        is_alu     = 1'b1;
        alu_result = '0;
        case (opcode)
            ADD:  alu_result = rf_rdata_a + rf_rdata_b;
            SUB:  alu_result = rf_rdata_a - rf_rdata_b;
            XOR:  alu_result = rf_rdata_a ^ rf_rdata_b;
            AND:  alu_result = rf_rdata_a & rf_rdata_b;
            ADDI: alu_result = rf_rdata_a + imm_sext;
            LUI:  alu_result = {instr_q.i.imm, 16'h0000};
            default: begin
                is_alu = 1'b0;
            end
        endcase
    end

    // Port b reads rd for stores, rs2 otherwise
    assign rf_raddr_a = instr_q.r.rs1;
    assign rf_raddr_b = is_store ? instr_q.i.rd : instr_q.r.rs2;
    assign rf_waddr   = instr_q.r.rd;

    // ALU results at the end of EXEC, load data on its rvalid
    assign rf_we = ((state_q == EXEC) && is_alu) ||
                   ((state_q == DATA_WAIT) && core_data_resp_i.rvalid && !is_store);
    assign rf_wdata = (state_q == DATA_WAIT) ? core_data_resp_i.rdata : alu_result;

    register_file register_file_inst (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .waddr_i   (rf_waddr),
        .we_i      (rf_we),
        .wdata_i   (rf_wdata),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fetch_enable_i) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                if (core_instr_resp_i.gnt) begin
                    state_d = WAIT_INSTR;
                end
            end
            WAIT_INSTR: begin
                if (core_instr_resp_i.rvalid) begin
                    state_d = EXEC;
                end
            end
            EXEC: begin
                if (opcode == HALT) begin
                    state_d = HALTED;
                end else if (is_mem) begin
                    state_d = DATA_REQ;
                end else begin
                    state_d = FETCH;
                end
            end
            DATA_REQ: begin
                if (core_data_resp_i.gnt) begin
                    state_d = DATA_WAIT;
                end
            end
            DATA_WAIT: begin
                if (core_data_resp_i.rvalid) begin
                    state_d = FETCH;
                end
            end
            HALTED:  state_d = HALTED;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            pc_q    <= `MCU_BOOT_ADDR;
        end else begin
            state_q <= state_d;
            // No branches, so the PC only steps forward
            if ((state_q == EXEC) && (opcode != HALT)) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == WAIT_INSTR) && core_instr_resp_i.rvalid) begin
            instr_q <= instr_u'(core_instr_resp_i.rdata);
        end
    end

    // Fetch port is read-only
    assign core_instr_req_o.req   = (state_q == FETCH);
    assign core_instr_req_o.we    = 1'b0;
    assign core_instr_req_o.be    = 4'b1111;
    assign core_instr_req_o.addr  = pc_q;
    assign core_instr_req_o.wdata = '0;

    // Word aligned, full word accesses only
    assign addr_sum               = rf_rdata_a + imm_sext;
    assign core_data_req_o.req    = (state_q == DATA_REQ);
    assign core_data_req_o.we     = is_store;
    assign core_data_req_o.be     = 4'b1111;
    assign core_data_req_o.addr   = {addr_sum[31:2], 2'b00};
    assign core_data_req_o.wdata  = is_store ? rf_rdata_b : '0;

    assign core_sleep_o = (state_q == HALTED);

endmodule

`default_nettype wire

// ==== rtl/instr_sram.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction SRAM with an OBI slave port and a host loader write port
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "mcu_params.svh"

module instr_sram #(
    parameter int unsigned DEPTH = `MCU_IMEM_WORDS
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  obi_pkg::obi_req_t  obi_req_i,
    output obi_pkg::obi_resp_t obi_resp_o,
    input  logic               host_we_i,
    input  logic [5:0]         host_addr_i,
    input  logic [31:0]        host_wdata_i
);

    localparam int unsigned AW = $clog2(DEPTH);

    logic [31:0]   mem [DEPTH];
    logic [31:0]   offset;
    logic [AW-1:0] rd_idx;
    logic [AW-1:0] wr_idx;
    logic [31:0]   rdata_q;
    logic          rvalid_q;

    // Word index relative to the boot address and wrapped at the depth
    assign offset = obi_req_i.addr - `MCU_BOOT_ADDR;
    assign rd_idx = AW'(offset[31:2] % DEPTH);
    assign wr_idx = AW'(host_addr_i);

    // Loader writes and registered fetch data
    always_ff @(posedge clk_i) begin
        if (host_we_i) begin
            mem[wr_idx] <= host_wdata_i;
        end
        if (obi_req_i.req) begin
            rdata_q <= mem[rd_idx];
        end
    end

    // One response per accepted request in the next cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= obi_req_i.req;
        end
    end

    // Never stalls
    assign obi_resp_o.gnt    = obi_req_i.req;
    assign obi_resp_o.rvalid = rvalid_q;
    assign obi_resp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== rtl/mcu_params.svh ====
////////////////////////////////////////////////////////////////////////////
// Boot address, instruction memory depth and register count
////////////////////////////////////////////////////////////////////////////
`ifndef MCU_PARAMS_SVH
`define MCU_PARAMS_SVH

// First fetch address after reset
`define MCU_BOOT_ADDR 32'h0000_0100

// Instruction SRAM depth in words
`define MCU_IMEM_WORDS 64

// Architectural registers, r0 hardwired to zero
`define MCU_NUM_REGS 8

`endif

// ==== rtl/mini_isa_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Opcodes, instruction formats, instruction union and core state enum
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package mini_isa_pkg;

    // Unlisted codes execute as no-ops
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        XOR  = 4'h2,
        AND  = 4'h3,
        ADDI = 4'h4,
        LUI  = 4'h5,
        LW   = 4'h6,
        SW   = 4'h7,
        HALT = 4'h8
    } opcode_e;

    // Register form
    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  rd;
        logic [2:0]  rs1;
        logic [2:0]  rs2;
        logic [18:0] unused;
    } instr_r_t;

    // Immediate form, imm sits in the low half
    typedef struct packed {
        opcode_e            opcode;
        logic [2:0]         rd;
        logic [2:0]         rs1;
        logic [5:0]         unused;
        logic signed [15:0] imm;
    } instr_i_t;

    // Fetched word, opcode selects which view applies
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_INSTR,
        EXEC,
        DATA_REQ,
        DATA_WAIT,
        HALTED
    } core_state_e;

endpackage

`default_nettype wire

// ==== rtl/mini_mcu.sv ====
////////////////////////////////////////////////////////////////////////////
// MCU top level, core subsystem and instruction SRAM
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module mini_mcu (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               fetch_enable_i,
    input  logic               host_we_i,
    input  logic [5:0]         host_addr_i,
    input  logic [31:0]        host_wdata_i,
    output obi_pkg::obi_req_t  core_data_req_o,
    input  obi_pkg::obi_resp_t core_data_resp_i,
    output logic               core_sleep_o
);
    import obi_pkg::*;

    // Internal instruction bus
    obi_req_t  core_instr_req;
    obi_resp_t core_instr_resp;

    cpu_subsystem cpu_subsystem_inst (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .fetch_enable_i    (fetch_enable_i),
        .core_instr_req_o  (core_instr_req),
        .core_instr_resp_i (core_instr_resp),
        .core_data_req_o   (core_data_req_o),
        .core_data_resp_i  (core_data_resp_i),
        .core_sleep_o      (core_sleep_o)
    );

    instr_sram instr_sram_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .obi_req_i    (core_instr_req),
        .obi_resp_o   (core_instr_resp),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i)
    );

endmodule

`default_nettype wire

// ==== rtl/obi_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI request and response structs used by the instruction and data buses
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package obi_pkg;

    // Master to slave, held stable until gnt
    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } obi_req_t;

    // Slave to master
    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } obi_resp_t;

endpackage

`default_nettype wire

// ==== rtl/register_file.sv ====
////////////////////////////////////////////////////////////////////////////
// Flip-flop register file, two async read ports and one write port
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "mcu_params.svh"

module register_file (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [2:0]  raddr_a_i,
    input  logic [2:0]  raddr_b_i,
    input  logic [2:0]  waddr_i,
    input  logic        we_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o
);

    logic [31:0] regs_q [`MCU_NUM_REGS];

    // r0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `MCU_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != 3'd0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Combinational reads
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then search the log
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mini_mcu_tb -Mdir obj_dir -o mini_mcu_sim -f sim.f
./obj_dir/mini_mcu_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "All tests passed!" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== sim.f ====
+incdir+rtl
rtl/obi_pkg.sv
rtl/mini_isa_pkg.sv
rtl/register_file.sv
rtl/instr_sram.sv
rtl/cpu_subsystem.sv
rtl/mini_mcu.sv
tests/mini_mcu_props.sv
tests/mini_mcu_tb.sv

// ==== tests/mini_mcu_props.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI master properties for cpu_subsystem, attached with bind
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module mini_mcu_props (
    input logic                      clk_i,
    input logic                      arst_n_i,
    input obi_pkg::obi_req_t         core_instr_req_i,
    input obi_pkg::obi_resp_t        core_instr_resp_i,
    input obi_pkg::obi_req_t         core_data_req_i,
    input obi_pkg::obi_resp_t        core_data_resp_i,
    input mini_isa_pkg::core_state_e state_i
);
    timeunit 1ns;
    timeprecision 100ps;

    import mini_isa_pkg::*;

    logic instr_busy_q;
    logic data_busy_q;

    // Set between grant and rvalid on each bus
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_busy_q <= 1'b0;
            data_busy_q  <= 1'b0;
        end else begin
            if (core_instr_req_i.req && core_instr_resp_i.gnt) begin
                instr_busy_q <= 1'b1;
            end else if (core_instr_resp_i.rvalid) begin
                instr_busy_q <= 1'b0;
            end
            if (core_data_req_i.req && core_data_resp_i.gnt) begin
                data_busy_q <= 1'b1;
            end else if (core_data_resp_i.rvalid) begin
                data_busy_q <= 1'b0;
            end
        end
    end

    data_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        core_data_req_i.req && !core_data_resp_i.gnt |=> $stable(core_data_req_i))
        else $error("data request changed before gnt");

    instr_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_busy_q |-> !core_instr_req_i.req)
        else $error("new instruction request before rvalid");

    data_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        data_busy_q |-> !core_data_req_i.req)
        else $error("new data request before rvalid");

    halted_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (state_i == HALTED) |-> !core_instr_req_i.req && !core_data_req_i.req)
        else $error("request issued while halted");

endmodule

bind cpu_subsystem mini_mcu_props mini_mcu_props_inst (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .core_instr_req_i  (core_instr_req_o),
    .core_instr_resp_i (core_instr_resp_i),
    .core_data_req_i   (core_data_req_o),
    .core_data_resp_i  (core_data_resp_i),
    .state_i           (state_q)
);

`default_nettype wire

// ==== tests/mini_mcu_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for mini_mcu: random programs, data memory responder,
// reference model and result checks
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "mcu_params.svh"

module mini_mcu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import obi_pkg::*;
    import mini_isa_pkg::*;

    localparam int          NUM_TESTS     = 8;
    localparam int          MAX_INSTR     = 40;
    localparam int          HALT_TIMEOUT  = MAX_INSTR * 12;
    localparam int          CLK_HALF      = 2;
    localparam int          DATA_WORDS    = 16;
    localparam logic [31:0] DATA_BASE     = 32'h0000_0200;

    // One data bus transfer with wdata zero for reads
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } txn_t;

    logic        clk;
    logic        arst_n;
    logic        fetch_enable;
    logic        host_we;
    logic [5:0]  host_addr;
    logic [31:0] host_wdata;
    obi_req_t    core_data_req;
    obi_resp_t   core_data_resp;
    logic        core_sleep;

    integer      seed;
    int          test_errors;
    logic        delays_on;
    logic [31:0] prog [$];
    logic [31:0] dmem [DATA_WORDS];
    logic [31:0] model_mem [DATA_WORDS];
    logic [31:0] model_regs [`MCU_NUM_REGS];
    txn_t        exp_txns [$];
    txn_t        act_txns [$];

    mini_mcu mini_mcu_inst (
        .clk_i            (clk),
        .arst_n_i         (arst_n),
        .fetch_enable_i   (fetch_enable),
        .host_we_i        (host_we),
        .host_addr_i      (host_addr),
        .host_wdata_i     (host_wdata),
        .core_data_req_o  (core_data_req),
        .core_data_resp_i (core_data_resp),
        .core_sleep_o     (core_sleep)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Word slot inside the data window
    function automatic logic [3:0] word_slot(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - DATA_BASE;
        return off[5:2];
    endfunction

    function automatic logic [31:0] encode(input opcode_e op, input logic [2:0] rd,
                                           input logic [2:0] rs1, input logic [2:0] rs2,
                                           input logic [15:0] imm);
        return {op, rd, rs1, rs2, 3'b000, imm};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            test_errors++;
        end
    endtask

    // Random body followed by a dump of every register and HALT
    task automatic build_program();
        int unsigned n;
        opcode_e     op;
        logic [15:0] imm;
        n = 8 + rand_below(24);
        prog.delete();
        for (int unsigned k = 0; k < n; k++) begin
            op = opcode_e'(4'(rand_below(8)));
            if (op == LW || op == SW) begin
                // Random low address bits that the core drops
                imm = 16'(DATA_BASE + 4 * rand_below(DATA_WORDS) + rand_below(4));
                prog.push_back(encode(op, 3'(rand_below(8)), 3'd0, 3'd0, imm));
            end else begin
                imm = 16'(rand_below(65536));
                prog.push_back(encode(op, 3'(rand_below(8)), 3'(rand_below(8)),
                                      3'(rand_below(8)), imm));
            end
        end
        for (int r = 0; r < `MCU_NUM_REGS; r++) begin
            prog.push_back(encode(SW, 3'(r), 3'd0, 3'd0, 16'(DATA_BASE + 4 * r)));
        end
        prog.push_back(encode(HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
    endtask

    task automatic run_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] res;
        logic [2:0]  rd;
        logic        wr;
        exp_txns.delete();
        for (int r = 0; r < `MCU_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        for (int k = 0; k < DATA_WORDS; k++) begin
            model_mem[k] = dmem[k];
        end
        foreach (prog[k]) begin
            w    = prog[k];
            rd   = w[27:25];
            a    = model_regs[w[24:22]];
            b    = model_regs[w[21:19]];
            imm  = {{16{w[15]}}, w[15:0]};
            addr = (a + imm) & 32'hFFFF_FFFC;
            res  = '0;
            wr   = 1'b1;
            case (w[31:28])
                ADD:  res = a + b;
                SUB:  res = a - b;
                XOR:  res = a ^ b;
                AND:  res = a & b;
                ADDI: res = a + imm;
                LUI:  res = {w[15:0], 16'h0000};
                LW: begin
                    res = model_mem[word_slot(addr)];
                    exp_txns.push_back({1'b0, addr, 32'h0});
                end
                SW: begin
                    wr = 1'b0;
                    exp_txns.push_back({1'b1, addr, model_regs[rd]});
                    model_mem[word_slot(addr)] = model_regs[rd];
                end
                default: wr = 1'b0;
            endcase
            // r0 ignores writes
            if (wr && rd != 3'd0) begin
                model_regs[rd] = res;
            end
        end
    endtask

    // Loader writes one word per cycle while the core sits idle
    task automatic load_program();
        foreach (prog[k]) begin
            @(posedge clk);
            host_we    <= 1'b1;
            host_addr  <= 6'(k);
            host_wdata <= prog[k];
            @(negedge clk);
            check_value("core_data_req_o.req", 32'(core_data_req.req), 32'h0);
            check_value("core_sleep_o", 32'(core_sleep), 32'h0);
        end
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    task automatic compare_results();
        check_value("data transfer count", act_txns.size(), exp_txns.size());
        for (int k = 0; k < exp_txns.size() && k < act_txns.size(); k++) begin
            check_value($sformatf("core_data_req_o.we[%0d]", k),
                        32'(act_txns[k].we), 32'(exp_txns[k].we));
            check_value($sformatf("core_data_req_o.addr[%0d]", k),
                        act_txns[k].addr, exp_txns[k].addr);
            check_value($sformatf("core_data_req_o.wdata[%0d]", k),
                        act_txns[k].wdata, exp_txns[k].wdata);
        end
        for (int k = 0; k < DATA_WORDS; k++) begin
            check_value($sformatf("dmem[%0d]", k), dmem[k], model_mem[k]);
        end
    endtask

    // Data memory slave with random gnt and rvalid delays
    initial begin : data_responder
        obi_req_t    req_s;
        logic        gnt_s;
        logic        arst_s;
        txn_t        seen;
        logic [31:0] off;
        logic [31:0] rdata;
        logic        pending;
        int unsigned gnt_wait;
        int unsigned rv_wait;
        core_data_resp <= '0;
        pending  = 1'b0;
        gnt_wait = 0;
        rv_wait  = 0;
        rdata    = '0;
        forever begin
            @(negedge clk);
            req_s  = core_data_req;
            gnt_s  = core_data_resp.gnt;
            arst_s = arst_n;
            @(posedge clk);
            core_data_resp.gnt    <= 1'b0;
            core_data_resp.rvalid <= 1'b0;
            if (!arst_s) begin
                pending  = 1'b0;
                gnt_wait = 0;
            end else begin
                if (req_s.req && gnt_s) begin
                    check_value("core_data_req_o.be", 32'(req_s.be), 32'h0000_000F);
                    seen.we    = req_s.we;
                    seen.addr  = req_s.addr;
                    seen.wdata = req_s.we ? req_s.wdata : 32'h0;
                    act_txns.push_back(seen);
                    off = req_s.addr - DATA_BASE;
                    if (off >= 32'(DATA_WORDS * 4)) begin
                        $display("data access outside the data window at 0x%08h", req_s.addr);
                        test_errors++;
                        rdata = '0;
                    end else if (req_s.we) begin
                        dmem[word_slot(req_s.addr)] = req_s.wdata;
                    end else begin
                        rdata = dmem[word_slot(req_s.addr)];
                    end
                    pending = 1'b1;
                    rv_wait = delays_on ? 1 + rand_below(3) : 1;
                end
                if (pending) begin
                    rv_wait--;
                    if (rv_wait == 0) begin
                        core_data_resp.rvalid <= 1'b1;
                        core_data_resp.rdata  <= rdata;
                        pending  = 1'b0;
                        gnt_wait = delays_on ? rand_below(4) : 0;
                    end
                end else if (gnt_wait == 0) begin
                    core_data_resp.gnt <= 1'b1;
                end else if (req_s.req) begin
                    gnt_wait--;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_TESTS * MAX_INSTR * 12) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    initial begin : main_flow
        int errors;
        int failed_tests;
        int cycles;
        seed         = 32'ha643_c488;
        errors       = 0;
        failed_tests = 0;
        arst_n       <= 1'b0;
        fetch_enable <= 1'b0;
        host_we      <= 1'b0;
        host_addr    <= '0;
        host_wdata   <= '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            // First test runs with zero-wait responses
            delays_on = (t != 0);
            @(posedge clk);
            arst_n       <= 1'b0;
            fetch_enable <= 1'b0;
            act_txns.delete();
            for (int k = 0; k < DATA_WORDS; k++) begin
                dmem[k] = $random(seed);
            end
            build_program();
            run_model();
            repeat (3) @(posedge clk);
            arst_n <= 1'b1;
            load_program();
            @(posedge clk);
            fetch_enable <= 1'b1;
            cycles = 0;
            while (!core_sleep && cycles < HALT_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!core_sleep) begin
                $display("test %0d: core did not halt within %0d cycles", t, cycles);
                test_errors++;
            end else begin
                repeat (20) begin
                    @(negedge clk);
                    assert (!core_data_req.req && core_sleep) else begin
                        $display("test %0d: data request or wake-up after HALT", t);
                        test_errors++;
                    end
                end
                compare_results();
            end
            $display("test %0d: %0d instructions, %0d data transfers, delays %s, %0d errors",
                     t, prog.size(), exp_txns.size(), delays_on ? "on" : "off", test_errors);
            errors += test_errors;
            if (test_errors != 0) begin
                failed_tests++;
            end
        end
        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
